/* iot_pkg.sv */
package iot_pkg;

	// --------------------
	// data sizes
	// --------------------
	localparam int BYTES_PER_WORD = 16;
	localparam int BYTE_W = 8;
	localparam int WORD_W = BYTES_PER_WORD * BYTE_W; // 128 bits
	localparam int CRC_W = 3;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [CRC_W-1:0] crc_rem_t;

	// generator x^3 + x^2 + 1, leading term implied
	localparam crc_rem_t CRC_POLY = 3'b101;

	// --------------------
	// function codes
	// --------------------
	// 1 and 2 are not implemented, any other value is treated as illegal
	typedef enum logic [2:0] {
		CRC_GEN  = 3'd3,
		TOP2MAX  = 3'd4,
		LAST2MIN = 3'd5
	} fn_e;

	// --------------------
	// handshake bundles
	// --------------------
	typedef struct packed {
		logic  valid;
		word_t data;
	} result_t; // unit and processor result

	typedef struct packed {
		logic  valid;
		word_t data;
	} word_req_t; // word handed to a unit

endpackage

/* byte_assembler.sv */
module byte_assembler
	import iot_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  in_en,
	input  byte_t iot_in,
	output logic  push,
	output word_t push_word
);

	localparam int CNT_W = $clog2(BYTES_PER_WORD);

	logic [CNT_W-1:0] byte_cnt; // bytes of the current word so far
	logic             word_done;
	logic             push_r;
	word_t            shreg;

	// sixteenth byte of a word is being taken this cycle
	assign word_done = in_en && (byte_cnt == CNT_W'(BYTES_PER_WORD - 1));

	// --------------------
	// byte counter
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			byte_cnt <= '0;
		end else if (in_en) begin
			byte_cnt <= byte_cnt + 1'b1; // wraps after the last byte
		end
	end

	// push is a one cycle pulse after the last byte
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			push_r <= 1'b0;
		end else begin
			push_r <= word_done;
		end
	end

	// --------------------
	// shift register
	// --------------------
	// bytes enter at the bottom, so the first one ends up on top
	always_ff @(posedge clk) begin
		if (in_en) begin
			shreg <= {shreg[WORD_W-BYTE_W-1:0], iot_in};
		end
	end

	// shreg still holds the full word during the push cycle,
	// the next word only starts shifting in at its end
	assign push      = push_r;
	assign push_word = shreg;

endmodule

/* word_fifo.sv */
module word_fifo
	import iot_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  push,
	input  word_t push_word,
	input  logic  pop,
	output word_t head_word,
	output logic  empty,
	output logic  full
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	word_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = push && !full; // drop on full, source should never do that
	assign do_rd = pop && !empty;

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= push_word;
		end
	end

	assign head_word = mem[rd_ptr];
	assign empty     = (count == '0);
	assign full      = (count == CNT_W'(FIFO_DEPTH));

endmodule

/* crc3_unit.sv */
module crc3_unit
	import iot_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  word_req_t req,
	output result_t   res,
	output logic      done
);

	localparam int CNT_W = $clog2(BYTES_PER_WORD);

	logic [CNT_W-1:0] byte_cnt;
	logic             active;
	logic             step;
	logic             last_step;
	logic             done_r;
	word_t            shreg;
	word_t            cur_word;
	crc_rem_t         rem_r;
	crc_rem_t         rem_next;
	crc_rem_t         res_rem;

	// eight bit steps of the serial division, msb first
	function automatic crc_rem_t crc_byte(input crc_rem_t rem_in, input byte_t data);
		crc_rem_t r;
		logic     fb;
		r = rem_in;
		for (int i = BYTE_W - 1; i >= 0; i--) begin
			fb = r[CRC_W-1] ^ data[i];
			r  = {r[CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
		end
		return r;
	endfunction

	// the first byte is taken straight from the request
	assign cur_word  = active ? shreg : req.data;
	assign rem_next  = crc_byte(active ? rem_r : '0, cur_word[WORD_W-1 -: BYTE_W]);
	assign step      = active || req.valid;
	assign last_step = step && (byte_cnt == CNT_W'(BYTES_PER_WORD - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active   <= 1'b0;
			byte_cnt <= '0;
			done_r   <= 1'b0;
		end else begin
			done_r <= last_step;
			if (step) begin
				byte_cnt <= byte_cnt + 1'b1;
				active   <= !last_step;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (step) begin
			shreg <= cur_word << BYTE_W;
			rem_r <= rem_next;
		end
		if (last_step) begin
			res_rem <= rem_next; // augmented by three zeros in the end
		end
	end

	assign res  = '{valid: done_r, data: word_t'(res_rem)};
	assign done = done_r;

endmodule

/* extrema_tracker.sv */
module extrema_tracker
	import iot_pkg::*;
#(
	parameter int ROUND_WORDS = 8
) (
	input  logic      clk,
	input  logic      rst,
	input  word_req_t req,
	input  logic      find_max,
	output result_t   res,
	output logic      done
);

	localparam int CNT_W = $clog2(BYTES_PER_WORD);
	localparam int WC_W = (ROUND_WORDS > 1) ? $clog2(ROUND_WORDS) : 1;

	logic [CNT_W-1:0] byte_cnt;
	logic [CNT_W-1:0] idx;
	logic [WC_W-1:0]  word_cnt; // words of this round already taken
	logic             active;
	logic             step;
	logic             last_step;
	logic             last_word;
	logic             emit2;    // second result goes out this cycle
	logic             done_r;
	logic             res_valid_r;
	logic             gt_best_r, gt_second_r;
	logic             gt_best, gt_second;
	logic             take_best, take_second;
	byte_t            in_byte, b_byte, s_byte;
	word_t            in_r, cur_word;
	word_t            best_r, second_r;
	word_t            best_q, second_q;
	word_t            init_val;
	word_t            res_data_r;

	// --------------------
	// byte-serial compare
	// --------------------
	assign cur_word = active ? in_r : req.data;
	assign idx      = active ? byte_cnt : '0; // lsb first
	assign init_val = find_max ? '0 : '1;

	// at round start the stored extremes count as the reset value
	assign best_q   = (word_cnt == '0) ? init_val : best_r;
	assign second_q = (word_cnt == '0) ? init_val : second_r;

	assign in_byte = cur_word[BYTE_W*idx +: BYTE_W];
	assign b_byte  = best_q[BYTE_W*idx +: BYTE_W];
	assign s_byte  = second_q[BYTE_W*idx +: BYTE_W];

	// equal bytes keep what the lower bytes decided
	assign gt_best   = (in_byte == b_byte) ? (active && gt_best_r) : (in_byte > b_byte);
	assign gt_second = (in_byte == s_byte) ? (active && gt_second_r) : (in_byte > s_byte);

	assign take_best   = find_max ? gt_best : !gt_best;
	assign take_second = find_max ? gt_second : !gt_second;

	assign step      = active || req.valid;
	assign last_step = step && (idx == CNT_W'(BYTES_PER_WORD - 1));
	assign last_word = (word_cnt == WC_W'(ROUND_WORDS - 1));

	// --------------------
	// control
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active      <= 1'b0;
			byte_cnt    <= '0;
			word_cnt    <= '0;
			emit2       <= 1'b0;
			done_r      <= 1'b0;
			res_valid_r <= 1'b0;
		end else begin
			done_r      <= emit2 || (last_step && !last_word);
			res_valid_r <= emit2 || (last_step && last_word);
			emit2       <= last_step && last_word;
			if (step) begin
				byte_cnt <= idx + 1'b1;
				active   <= !last_step;
			end
			if (last_step) begin
				word_cnt <= last_word ? '0 : word_cnt + 1'b1; // new round after the last
			end
		end
	end

	// --------------------
	// data path
	// --------------------
	always_ff @(posedge clk) begin
		if (step) begin
			gt_best_r   <= gt_best;
			gt_second_r <= gt_second;
		end
		if (req.valid && !active) begin
			in_r <= req.data;
		end
		if (last_step) begin
			best_r   <= best_q;
			second_r <= second_q;
			if (take_best) begin
				best_r   <= cur_word;
				second_r <= best_q;
			end else if (take_second) begin
				second_r <= cur_word;
			end
			res_data_r <= take_best ? cur_word : best_q; // best of the round
		end
		if (emit2) begin
			res_data_r <= second_r;
		end
	end

	assign res  = '{valid: res_valid_r, data: res_data_r};
	assign done = done_r;

endmodule

/* iot_processor.sv */
module iot_processor
	import iot_pkg::*;
#(
	parameter int ROUND_WORDS = 8
) (
	input  logic  clk,
	input  logic  rst,
	input  fn_e   fn_sel,
	input  logic  empty,
	input  word_t head_word,
	output logic  pop,
	output logic  valid,
	output word_t iot_out
);

	typedef enum logic {
		P_IDLE,
		P_BUSY
	} proc_state_e;

	proc_state_e state;
	fn_e         fn_r;
	logic        fn_lock;  // code sampled since reset
	logic        is_crc, is_ext;
	logic        find_max;
	logic        crc_done, ext_done, unit_done;
	logic        valid_r;
	word_t       iot_out_r;
	word_req_t   crc_req, ext_req;
	result_t     crc_res, ext_res, sel_res;

	// --------------------
	// function select
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fn_lock <= 1'b0;
		end else begin
			fn_lock <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!fn_lock) begin
			fn_r <= fn_sel; // held until the next reset
		end
	end

	assign is_crc   = fn_lock && (fn_r == CRC_GEN);
	assign is_ext   = fn_lock && ((fn_r == TOP2MAX) || (fn_r == LAST2MIN));
	assign find_max = (fn_r == TOP2MAX);

	// illegal codes never pop, so nothing comes out
	assign pop = (state == P_IDLE) && !empty && (is_crc || is_ext);

	assign crc_req = '{valid: pop && is_crc, data: head_word};
	assign ext_req = '{valid: pop && is_ext, data: head_word};

	assign unit_done = is_crc ? crc_done : ext_done;
	assign sel_res   = is_crc ? crc_res : ext_res;

	// one word in flight at a time
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= P_IDLE;
		end else if (pop) begin
			state <= P_BUSY;
		end else if (unit_done) begin
			state <= P_IDLE;
		end
	end

	crc3_unit u_crc (.clk(clk), .rst(rst), .req(crc_req), .res(crc_res), .done(crc_done));

	extrema_tracker #(
		.ROUND_WORDS(ROUND_WORDS)
	) u_ext (
		.clk(clk),
		.rst(rst),
		.req(ext_req),
		.find_max(find_max),
		.res(ext_res),
		.done(ext_done)
	);

	// --------------------
	// output register
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_r <= 1'b0;
		end else begin
			valid_r <= sel_res.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_res.valid) begin
			iot_out_r <= sel_res.data;
		end
	end

	assign valid   = valid_r;
	assign iot_out = iot_out_r;

endmodule

/* iot_filter_top.sv */
module iot_filter_top
	import iot_pkg::*;
#(
	parameter int FIFO_DEPTH = 4,
	parameter int ROUND_WORDS = 8
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  in_en,
	input  byte_t iot_in,
	input  fn_e   fn_sel,
	output logic  busy,
	output logic  valid,
	output word_t iot_out
);

	logic  push, pop, empty;
	word_t push_word, head_word;

	// producer
	byte_assembler u_asm (
		.clk(clk), .rst(rst), .in_en(in_en), .iot_in(iot_in),
		.push(push), .push_word(push_word)
	);

	// buffer, its full flag is the busy output
	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .rst(rst), .push(push), .push_word(push_word), .pop(pop),
		.head_word(head_word), .empty(empty), .full(busy)
	);

	// consumer
	iot_processor #(.ROUND_WORDS(ROUND_WORDS)) u_proc (
		.clk(clk), .rst(rst), .fn_sel(fn_sel), .empty(empty), .head_word(head_word),
		.pop(pop), .valid(valid), .iot_out(iot_out)
	);

endmodule

/* iot_filter_assertions.sv */
module iot_filter_assertions
	import iot_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_en,
	input logic busy,
	input logic valid,
	input fn_e  fn_sel
);

	// source must respect the full buffer
	assert property (@(posedge clk) disable iff (rst) in_en |-> !busy)
		else $error("in_en high while busy");

	assert property (@(posedge clk) rst |-> !valid)
		else $error("valid high during reset");

	// only the three implemented codes
	assert property (@(posedge clk) disable iff (rst)
		fn_sel inside {CRC_GEN, TOP2MAX, LAST2MIN})
		else $error("illegal function code");

endmodule

bind iot_filter_top iot_filter_assertions u_assert (
	.clk(clk),
	.rst(rst),
	.in_en(in_en),
	.busy(busy),
	.valid(valid),
	.fn_sel(fn_sel)
);

/* tb_iot_filter.sv */
module tb_iot_filter
	import iot_pkg::*;
;

	localparam int BUSY_LIMIT = 400;   // cycles a single byte may wait on busy
	localparam int RESULT_LIMIT = 4000;
	localparam int QUIET_CYCLES = 40;

	logic  clk;
	logic  rst;
	logic  in_en;
	byte_t iot_in;
	fn_e   fn_sel;
	logic  busy;
	logic  valid;
	word_t iot_out;

	word_t word_q[$];  // words of the current section
	word_t exp_q[$];   // expected results in order
	word_t got_q[$];   // results seen on the output
	int    sec_mode;
	int    sec_gaps;
	logic  saw_busy;

	iot_filter_top #(
		.FIFO_DEPTH(4),
		.ROUND_WORDS(8)
	) uut (
		.clk(clk),
		.rst(rst),
		.in_en(in_en),
		.iot_in(iot_in),
		.fn_sel(fn_sel),
		.busy(busy),
		.valid(valid),
		.iot_out(iot_out)
	);

	always #10 clk = ~clk;

	// output collector
	always @(posedge clk) begin
		if (!rst && valid) begin
			got_q.push_back(iot_out);
		end
	end

	// ---------------------
	// report helpers
	// ---------------------
	task automatic stop_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic stop_on_mismatch(input string msg);
		$display("Fail %0t: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_crc(input crc_rem_t exp, input word_t got, input int idx);
		if (got[CRC_W-1:0] !== exp || got[WORD_W-1:CRC_W] !== '0) begin
			stop_on_mismatch($sformatf("crc result %0d expected %0h got %0h", idx, exp, got));
		end
	endtask

	task automatic check_extreme(input word_t exp, input word_t got, input int idx);
		if (got !== exp) begin
			stop_on_mismatch($sformatf("extreme result %0d expected %0h got %0h",
				idx, exp, got));
		end
	endtask

	// ---------------------
	// stimulus
	// ---------------------
	task automatic send_byte(input byte_t b);
		int waited;
		int gap;
		waited = 0;
		while (busy) begin // fifo full, hold off
			saw_busy = 1'b1;
			@(posedge clk);
			#2;
			waited++;
			if (waited > BUSY_LIMIT) begin
				stop_on_timeout("busy to fall");
			end
		end
		in_en  = 1'b1;
		iot_in = b;
		@(posedge clk);
		#2;
		in_en = 1'b0;
		gap = (sec_gaps != 0) ? $urandom_range(3, 0) : 0;
		repeat (gap) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_word(input word_t w);
		for (int i = BYTES_PER_WORD - 1; i >= 0; i--) begin
			send_byte(w[BYTE_W*i +: BYTE_W]); // most significant byte first
		end
	endtask

	task automatic apply_reset();
		rst    = 1'b1;
		in_en  = 1'b0;
		iot_in = '0;
		fn_sel = fn_e'(sec_mode);
		repeat (10) @(posedge clk);
		#2;
		got_q.delete();
		rst = 1'b0;
	endtask

	task automatic run_section();
		int waited;
		apply_reset();
		saw_busy = 1'b0;
		foreach (word_q[i]) begin
			send_word(word_q[i]);
		end
		if (sec_gaps == 0 && !saw_busy) begin
			$display("busy never rose during the back-to-back section");
			$display("** FAIL **");
			$fatal(1, "simulation stopped");
		end
		waited = 0;
		while (got_q.size() < exp_q.size()) begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > RESULT_LIMIT) begin
				stop_on_timeout("valid results");
			end
		end
		repeat (QUIET_CYCLES) @(posedge clk); // nothing more may come out
		#2;
		if (got_q.size() != exp_q.size()) begin
			stop_on_mismatch($sformatf("expected %0d results, got %0d",
				exp_q.size(), got_q.size()));
		end
		foreach (exp_q[i]) begin
			if (sec_mode == CRC_GEN) begin
				check_crc(crc_rem_t'(exp_q[i]), got_q[i], i);
			end else begin
				check_extreme(exp_q[i], got_q[i], i);
			end
		end
		word_q.delete();
		exp_q.delete();
	endtask

	// ---------------------
	// main sequence
	// ---------------------
	initial begin
		int    fd;
		int    code;
		int    cnt;
		byte   tag;
		string line;
		word_t w;
		word_t e;
		logic  open_sec;
		clk        = 1'b0;
		rst        = 1'b1;
		in_en      = 1'b0;
		iot_in     = '0;
		fn_sel     = CRC_GEN;
		open_sec   = 1'b0;
		void'($urandom(47264));
		fd = $fopen("iot_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open iot_golden.txt");
			$display("** FAIL **");
			$fatal(1, "simulation stopped");
		end
		forever begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) break;
			if (tag == "#") begin
				code = $fgets(line, fd); // comment line
			end else if (tag == "M") begin
				if (open_sec) run_section();
				code = $fscanf(fd, "%d %d", sec_mode, sec_gaps);
				open_sec = 1'b1;
			end else if (tag == "W") begin
				code = $fscanf(fd, "%h", w);
				word_q.push_back(w);
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h", e);
				exp_q.push_back(e);
			end else if (tag == "B") begin
				code = $fscanf(fd, "%h %d %h", w, cnt, e); // repeated word
				repeat (cnt) begin
					word_q.push_back(w);
					exp_q.push_back(e);
				end
			end
		end
		$fclose(fd);
		if (open_sec) run_section();
		$display("** PASS **");
		$finish;
	end

endmodule

/* iot_golden.txt */
# M mode gaps (gaps 1 = random idle cycles between bytes, 0 = back to back)
# W input word, E expected result, B word count expected_crc (word repeated)
M 3 1
W 0
W ffffffffffffffffffffffffffffffff
W 2
W 10
E 0
E 2
E 7
E 1
M 4 1
W 5
W 9
W 3
W 100
W 7
W ff
W 2
W 80
E 100
E ff
W 11223344556677889900aabbccddee01
W 11223344556677889900aabbccddee05
W 11223344556677889900aabbccddee03
W 01ffffffffffffffffffffffffffffff
W 0
W 10ffffffffffffffffffffffffffffff
W 11223344556677889900aabbccddee04
W 1
E 11223344556677889900aabbccddee05
E 11223344556677889900aabbccddee04
M 5 1
W 50
W 7
W 30
W 7
W 99
W 100
W 8
W 7fffffffffffffffffffffffffffffff
E 7
E 7
W ffffffffffffffffffffffffffffffff
W 301
W 300
W 1300
W 300
W ffff
W 400
W 302
E 300
E 300
M 3 0
B 1 30 5
B 4 30 3
B 20 30 2
B 40 30 4

/* sim.f */
iot_pkg.sv
byte_assembler.sv
word_fifo.sv
crc3_unit.sv
extrema_tracker.sv
iot_processor.sv
iot_filter_top.sv
iot_filter_assertions.sv
tb_iot_filter.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module tb_iot_filter; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_iot_filter > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation did not finish"
	exit 1
fi

exit 0
